// ==== design/quad_settings.svh ====
`ifndef QUAD_SETTINGS_SVH
`define QUAD_SETTINGS_SVH

// Array sizes
`define NUM_CE          4
`define KERNEL_TAPS     3
`define PFB_DEPTH       8
`define SET_QUEUE_DEPTH 4

// Datapath widths
`define PIXEL_WIDTH     8
`define WEIGHT_WIDTH    8

// Three 16 bit products summed, with headroom
`define RESULT_WIDTH    20

// Pixel count of one job
`define COUNT_WIDTH     8

`endif

// ==== design/quad_pkg.sv ====
`include "quad_settings.svh"

package quad_pkg;

    // Signed datapath values
    typedef logic signed [`PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [`WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [`RESULT_WIDTH-1:0] result_t;

    // Pixel and result-set counts
    typedef logic [`COUNT_WIDTH-1:0] count_t;

    // Engine index times taps plus tap
    typedef logic [3:0] weight_addr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_active,
        st_drain,
        st_send_complete
    } job_state_t;

endpackage

// ==== design/job_ctrl.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module job_ctrl (
    input  logic             clk_core,
    input  logic             rst,
    input  logic             job_start,
    input  quad_pkg::count_t job_num_pixels,
    input  logic             job_relu,
    input  logic             job_complete_ack,
    input  logic             pixel_fire,
    input  logic             set_done,
    output logic             job_accept,
    output logic             job_complete,
    output logic             idle,
    output logic             fetch_enable,
    output logic             new_job,
    output logic             relu_en
);

    quad_pkg::job_state_t state;
    quad_pkg::count_t     num_pixels;
    quad_pkg::count_t     pixel_cnt;
    quad_pkg::count_t     set_cnt;
    quad_pkg::count_t     sets_expected;

    // One result set per window position
    assign sets_expected = num_pixels - quad_pkg::count_t'(`KERNEL_TAPS - 1);

    assign idle         = (state == quad_pkg::st_idle);
    assign new_job      = idle && job_start;
    assign fetch_enable = (state == quad_pkg::st_active) && (pixel_cnt != num_pixels);
    assign job_complete = (state == quad_pkg::st_send_complete);

    // Job parameters, captured on accept
    always_ff @(posedge clk_core) begin
        if (new_job) begin
            num_pixels <= job_num_pixels;
            relu_en    <= job_relu;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state      <= quad_pkg::st_idle;
            job_accept <= 1'b0;
            pixel_cnt  <= '0;
            set_cnt    <= '0;
        end else begin
            job_accept <= new_job;
            if (pixel_fire) begin
                pixel_cnt <= pixel_cnt + 1'b1;
            end
            if (set_done) begin
                set_cnt <= set_cnt + 1'b1;
            end

            case (state)
                quad_pkg::st_idle: begin
                    if (job_start) begin
                        state     <= quad_pkg::st_active;
                        pixel_cnt <= '0;
                        set_cnt   <= '0;
                    end
                end
                // All pixels taken in, results still in flight
                quad_pkg::st_active: begin
                    if (pixel_cnt == num_pixels) begin
                        state <= quad_pkg::st_drain;
                    end
                end
                quad_pkg::st_drain: begin
                    if (set_cnt == sets_expected) begin
                        state <= quad_pkg::st_send_complete;
                    end
                end
                quad_pkg::st_send_complete: begin
                    if (job_complete_ack) begin
                        state <= quad_pkg::st_idle;
                    end
                end
                default: state <= quad_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== design/prefetch_buffer.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module prefetch_buffer (
    input  logic             clk_core,
    input  logic             rst,
    input  logic             new_job,
    input  logic             fetch_enable,
    input  logic             pixel_valid,
    input  quad_pkg::pixel_t pixel_data,
    input  logic             pop,
    output logic             pixel_ready,
    output logic             pixel_fire,
    output quad_pkg::pixel_t pfb_data,
    output logic             pfb_empty
);

    localparam int AW = $clog2(`PFB_DEPTH);

    quad_pkg::pixel_t mem [`PFB_DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             full;
    logic             do_pop;

    assign full        = (count == (AW + 1)'(`PFB_DEPTH));
    assign pfb_empty   = (count == '0);
    assign pixel_ready = fetch_enable && !full;
    assign pixel_fire  = pixel_valid && pixel_ready;
    assign do_pop      = pop && !pfb_empty;

    // Head of the FIFO shown directly
    assign pfb_data = mem[rd_ptr];

    always_ff @(posedge clk_core) begin
        if (pixel_fire) begin
            mem[wr_ptr] <= pixel_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst || new_job) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (pixel_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({pixel_fire, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/pixel_window.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module pixel_window (
    input  logic             clk_core,
    input  logic             rst,
    input  logic             new_job,
    input  logic             relu_en,
    input  quad_pkg::pixel_t pfb_data,
    input  logic             pfb_empty,
    input  logic             space_ok,
    output logic             pop,
    output quad_pkg::pixel_t window [`KERNEL_TAPS],
    output logic             window_advance,
    output logic             window_valid
);

    localparam int            FW   = $clog2(`KERNEL_TAPS);
    localparam logic [FW-1:0] FULL = FW'(`KERNEL_TAPS - 1);

    quad_pkg::pixel_t history [`KERNEL_TAPS-1];
    quad_pkg::pixel_t pix_in;
    logic [FW-1:0]    fill;

    // Stall when the serializer has no room for sets in flight
    assign pop = !pfb_empty && space_ok;

    assign pix_in = (relu_en && pfb_data[`PIXEL_WIDTH-1]) ? '0 : pfb_data;

    // Window as it stands after this pop, newest pixel in the last tap
    always_comb begin
        for (int k = 0; k < `KERNEL_TAPS - 1; k++) begin
            window[k] = history[k];
        end
        window[`KERNEL_TAPS-1] = pix_in;
    end

    assign window_advance = pop;
    assign window_valid   = pop && (fill == FULL);

    always_ff @(posedge clk_core) begin
        if (pop) begin
            for (int k = 0; k < `KERNEL_TAPS - 2; k++) begin
                history[k] <= history[k+1];
            end
            history[`KERNEL_TAPS-2] <= pix_in;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst || new_job) begin
            fill <= '0;
        end else if (pop && fill != FULL) begin
            fill <= fill + 1'b1;
        end
    end

endmodule

// ==== design/weight_table.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module weight_table (
    input  logic                   clk_core,
    input  logic                   rst,
    input  logic                   idle,
    input  logic                   weight_valid,
    input  quad_pkg::weight_addr_t weight_addr,
    input  quad_pkg::weight_t      weight_data,
    output logic                   weight_ready,
    output quad_pkg::weight_t      kernel [`NUM_CE][`KERNEL_TAPS]
);

    logic weight_write;

    // Weights only change between jobs
    assign weight_ready = idle;
    assign weight_write = weight_valid && weight_ready;

    always_ff @(posedge clk_core) begin
        for (int c = 0; c < `NUM_CE; c++) begin
            for (int k = 0; k < `KERNEL_TAPS; k++) begin
                if (rst) begin
                    kernel[c][k] <= '0;
                end else if (weight_write &&
                             weight_addr == quad_pkg::weight_addr_t'(c * `KERNEL_TAPS + k)) begin
                    kernel[c][k] <= weight_data;
                end
            end
        end
    end

endmodule

// ==== design/conv_engine.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module conv_engine (
    input  logic              clk_core,
    input  logic              rst,
    input  quad_pkg::pixel_t  window [`KERNEL_TAPS],
    input  logic              window_advance,
    input  logic              window_valid,
    input  quad_pkg::weight_t taps [`KERNEL_TAPS],
    output quad_pkg::result_t ce_sum,
    output logic              ce_sum_valid
);

    localparam int PW = `PIXEL_WIDTH + `WEIGHT_WIDTH;

    logic signed [PW-1:0] prod_q [`KERNEL_TAPS];
    logic                 prod_valid;
    quad_pkg::result_t    sum_next;

    ////////////////////
    // Stage 1 products
    ////////////////////

    always_ff @(posedge clk_core) begin
        if (window_advance) begin
            for (int k = 0; k < `KERNEL_TAPS; k++) begin
                prod_q[k] <= PW'(window[k]) * PW'(taps[k]);
            end
        end
    end

    ////////////////////
    // Stage 2 sum
    ////////////////////

    always_comb begin
        sum_next = '0;
        for (int k = 0; k < `KERNEL_TAPS; k++) begin
            sum_next = sum_next + quad_pkg::result_t'(prod_q[k]);
        end
    end

    always_ff @(posedge clk_core) begin
        if (prod_valid) begin
            ce_sum <= sum_next;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            prod_valid   <= 1'b0;
            ce_sum_valid <= 1'b0;
        end else begin
            prod_valid   <= window_advance && window_valid;
            ce_sum_valid <= prod_valid;
        end
    end

endmodule

// ==== design/result_serializer.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module result_serializer (
    input  logic              clk_core,
    input  logic              rst,
    input  quad_pkg::result_t ce_sum [`NUM_CE],
    input  logic              ce_sum_valid,
    input  logic              result_ready,
    output logic              result_valid,
    output quad_pkg::result_t result_data,
    output logic              set_done,
    output logic              space_ok
);

    localparam int QW = $clog2(`SET_QUEUE_DEPTH);
    localparam int CW = $clog2(`NUM_CE);

    quad_pkg::result_t set_mem [`SET_QUEUE_DEPTH][`NUM_CE];
    logic [QW-1:0]     wr_ptr;
    logic [QW-1:0]     rd_ptr;
    logic [QW:0]       count;
    logic [CW-1:0]     ce_idx;
    logic              fire;

    assign result_valid = (count != '0);
    assign result_data  = set_mem[rd_ptr][ce_idx];
    assign fire         = result_valid && result_ready;
    assign set_done     = fire && (ce_idx == CW'(`NUM_CE - 1));

    // Three slots cover the sets still inside the window and engines
    assign space_ok = (count <= (QW + 1)'(`SET_QUEUE_DEPTH - 3));

    always_ff @(posedge clk_core) begin
        if (ce_sum_valid) begin
            for (int c = 0; c < `NUM_CE; c++) begin
                set_mem[wr_ptr][c] <= ce_sum[c];
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ce_idx <= '0;
        end else begin
            if (ce_sum_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Engine 0 first, then the next set
            if (set_done) begin
                rd_ptr <= rd_ptr + 1'b1;
                ce_idx <= '0;
            end else if (fire) begin
                ce_idx <= ce_idx + 1'b1;
            end
            case ({ce_sum_valid, set_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/quad_top.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module quad_top (
    input  logic                            clk_core,
    input  logic                            rst,

    input  logic                            job_start,
    input  logic [`COUNT_WIDTH-1:0]         job_num_pixels,
    input  logic                            job_relu,
    output logic                            job_accept,
    output logic                            job_complete,
    input  logic                            job_complete_ack,

    input  logic                            weight_valid,
    output logic                            weight_ready,
    input  logic [3:0]                      weight_addr,
    input  logic signed [`WEIGHT_WIDTH-1:0] weight_data,

    input  logic                            pixel_valid,
    output logic                            pixel_ready,
    input  logic signed [`PIXEL_WIDTH-1:0]  pixel_data,

    output logic                            result_valid,
    input  logic                            result_ready,
    output logic signed [`RESULT_WIDTH-1:0] result_data
);

    ////////////////////
    // Internal wiring
    ////////////////////

    logic                            idle;
    logic                            fetch_enable;
    logic                            new_job;
    logic                            relu_en;
    logic                            pixel_fire;
    logic                            set_done;
    logic signed [`PIXEL_WIDTH-1:0]  pfb_data;
    logic                            pfb_empty;
    logic                            pop;
    logic signed [`PIXEL_WIDTH-1:0]  window [`KERNEL_TAPS];
    logic                            window_advance;
    logic                            window_valid;
    logic                            space_ok;
    logic signed [`WEIGHT_WIDTH-1:0] kernel [`NUM_CE][`KERNEL_TAPS];
    logic signed [`RESULT_WIDTH-1:0] ce_sum [`NUM_CE];
    logic                            ce_sum_valid [`NUM_CE];

    job_ctrl u_job_ctrl (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_num_pixels   (job_num_pixels),
        .job_relu         (job_relu),
        .job_complete_ack (job_complete_ack),
        .pixel_fire       (pixel_fire),
        .set_done         (set_done),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .idle             (idle),
        .fetch_enable     (fetch_enable),
        .new_job          (new_job),
        .relu_en          (relu_en)
    );

    prefetch_buffer u_prefetch_buffer (
        .clk_core     (clk_core),
        .rst          (rst),
        .new_job      (new_job),
        .fetch_enable (fetch_enable),
        .pixel_valid  (pixel_valid),
        .pixel_data   (pixel_data),
        .pop          (pop),
        .pixel_ready  (pixel_ready),
        .pixel_fire   (pixel_fire),
        .pfb_data     (pfb_data),
        .pfb_empty    (pfb_empty)
    );

    pixel_window u_pixel_window (
        .clk_core       (clk_core),
        .rst            (rst),
        .new_job        (new_job),
        .relu_en        (relu_en),
        .pfb_data       (pfb_data),
        .pfb_empty      (pfb_empty),
        .space_ok       (space_ok),
        .pop            (pop),
        .window         (window),
        .window_advance (window_advance),
        .window_valid   (window_valid)
    );

    weight_table u_weight_table (
        .clk_core     (clk_core),
        .rst          (rst),
        .idle         (idle),
        .weight_valid (weight_valid),
        .weight_addr  (weight_addr),
        .weight_data  (weight_data),
        .weight_ready (weight_ready),
        .kernel       (kernel)
    );

    // One engine per kernel, all fed the same window
    generate
        for (genvar g = 0; g < `NUM_CE; g++) begin : g_ce
            conv_engine u_conv_engine (
                .clk_core       (clk_core),
                .rst            (rst),
                .window         (window),
                .window_advance (window_advance),
                .window_valid   (window_valid),
                .taps           (kernel[g]),
                .ce_sum         (ce_sum[g]),
                .ce_sum_valid   (ce_sum_valid[g])
            );
        end
    endgenerate

    result_serializer u_result_serializer (
        .clk_core     (clk_core),
        .rst          (rst),
        .ce_sum       (ce_sum),
        .ce_sum_valid (ce_sum_valid[0]),
        .result_ready (result_ready),
        .result_valid (result_valid),
        .result_data  (result_data),
        .set_done     (set_done),
        .space_ok     (space_ok)
    );

endmodule

// ==== tests/quad_asserts.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module quad_asserts (
    input logic                     clk_core,
    input logic                     rst,
    input logic                     idle,
    input logic                     job_accept,
    input logic                     job_complete,
    input logic                     job_complete_ack,
    input logic                     pixel_ready,
    input logic                     result_valid,
    input logic                     result_ready,
    input logic [`RESULT_WIDTH-1:0] result_data
);

    // Stalled result keeps valid and data
    result_hold: assert property (@(posedge clk_core) disable iff (rst)
        (result_valid && !result_ready) |=> (result_valid && $stable(result_data)))
        else $error("result_data or result_valid changed while the result was stalled");

    // Completion held until acknowledged
    complete_hold: assert property (@(posedge clk_core) disable iff (rst)
        (job_complete && !job_complete_ack) |=> job_complete)
        else $error("job_complete dropped without job_complete_ack");

    idle_no_pixels: assert property (@(posedge clk_core) disable iff (rst)
        idle |-> !pixel_ready)
        else $error("pixel_ready high while the quad is idle");

    accept_single: assert property (@(posedge clk_core) disable iff (rst)
        job_accept |=> !job_accept)
        else $error("job_accept high on two cycles in a row");

endmodule

bind quad_top quad_asserts u_quad_asserts (
    .clk_core         (clk_core),
    .rst              (rst),
    .idle             (idle),
    .job_accept       (job_accept),
    .job_complete     (job_complete),
    .job_complete_ack (job_complete_ack),
    .pixel_ready      (pixel_ready),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result_data      (result_data)
);

// ==== tests/quad_tb.sv ====
`timescale 1ns/1ns
`include "quad_settings.svh"

module quad_tb;

    localparam int N_TESTS      = 4;
    localparam int MAX_PIX      = 16;
    localparam int RESET_CYCLES = 3;
    localparam int N_WEIGHTS    = `NUM_CE * `KERNEL_TAPS;

    logic                            clk_core;
    logic                            rst;
    logic                            job_start;
    logic [`COUNT_WIDTH-1:0]         job_num_pixels;
    logic                            job_relu;
    logic                            job_accept;
    logic                            job_complete;
    logic                            job_complete_ack;
    logic                            weight_valid;
    logic                            weight_ready;
    logic [3:0]                      weight_addr;
    logic signed [`WEIGHT_WIDTH-1:0] weight_data;
    logic                            pixel_valid;
    logic                            pixel_ready;
    logic signed [`PIXEL_WIDTH-1:0]  pixel_data;
    logic                            result_valid;
    logic                            result_ready;
    logic signed [`RESULT_WIDTH-1:0] result_data;

    // Test table with one row per job
    string t_name   [N_TESTS];
    int    t_kernel [N_TESTS][`NUM_CE][`KERNEL_TAPS];
    int    t_count  [N_TESTS];
    int    t_pixels [N_TESTS][MAX_PIX];
    bit    t_relu   [N_TESTS];
    bit    t_rand   [N_TESTS];

    int seed            = 58;
    int value_errors    = 0;
    int protocol_errors = 0;
    bit table_loaded    = 1'b0;

    quad_top dut (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_num_pixels   (job_num_pixels),
        .job_relu         (job_relu),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .weight_valid     (weight_valid),
        .weight_ready     (weight_ready),
        .weight_addr      (weight_addr),
        .weight_data      (weight_data),
        .pixel_valid      (pixel_valid),
        .pixel_ready      (pixel_ready),
        .pixel_data       (pixel_data),
        .result_valid     (result_valid),
        .result_ready     (result_ready),
        .result_data      (result_data)
    );

    initial begin
        clk_core = 1'b0;
        forever #20 clk_core = ~clk_core;
    end

    ////////////////////
    // Table contents
    ////////////////////

    task automatic fill_table();
        t_name[0]   = "plain_conv";
        t_kernel[0] = '{'{1, 2, 3}, '{-1, 0, 1}, '{4, -2, 1}, '{-3, 5, -7}};
        t_count[0]  = 8;
        t_pixels[0] = '{10, -20, 30, -40, 50, 60, -70, 80, 0, 0, 0, 0, 0, 0, 0, 0};
        t_relu[0]   = 1'b0;
        t_rand[0]   = 1'b0;

        // Same pixels and kernel with negatives zeroed
        t_name[1]   = "relu_conv";
        t_kernel[1] = t_kernel[0];
        t_count[1]  = 8;
        t_pixels[1] = t_pixels[0];
        t_relu[1]   = 1'b1;
        t_rand[1]   = 1'b0;

        // Long enough to fill the prefetch buffer while results back up
        t_name[2]   = "backpressure";
        t_kernel[2] = '{'{7, -8, 9}, '{-128, 127, 2}, '{3, 3, 3}, '{0, -1, -5}};
        t_count[2]  = 16;
        t_pixels[2] = '{127, -128, 5, -6, 100, -100, 33, -33,
                        12, -12, 90, 45, -77, 64, 1, -1};
        t_relu[2]   = 1'b0;
        t_rand[2]   = 1'b1;

        t_name[3]   = "new_weights";
        t_kernel[3] = '{'{-5, 6, -7}, '{8, -9, 10}, '{11, 12, -13}, '{-14, 15, 16}};
        t_count[3]  = 8;
        t_pixels[3] = t_pixels[0];
        t_relu[3]   = 1'b0;
        t_rand[3]   = 1'b0;
    endtask

    function automatic int watchdog_cycles();
        int total;
        total = RESET_CYCLES;
        for (int t = 0; t < N_TESTS; t++) begin
            total += (t_count[t] * `NUM_CE + 20) * 4;
        end
        return total;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic protocol_error(input string msg);
        protocol_errors++;
        $display("%s", msg);
    endtask

    task automatic check_value(input string test, input string what, input int want,
                               input int got);
        assert (got == want) else begin
            value_errors++;
            $display("** Error: %s %s expected %0d actual %0d", test, what, want, got);
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic load_weights(input int t);
        for (int a = 0; a < N_WEIGHTS; a++) begin
            weight_valid = 1'b1;
            weight_addr  = 4'(a);
            weight_data  = `WEIGHT_WIDTH'(t_kernel[t][a / `KERNEL_TAPS][a % `KERNEL_TAPS]);
            @(negedge clk_core);
            assert (weight_ready) else
                protocol_error($sformatf("%s: weight_ready low while idle", t_name[t]));
            @(posedge clk_core);
            #2;
        end
        weight_valid = 1'b0;
    endtask

    task automatic run_row(input int t);
        int expected [$];
        int expected_plain [$];
        int n_pos;
        int sum;
        int sum_plain;
        int px;
        int pix_idx;
        int res_idx;
        int accept_cnt;
        int complete_cycles;
        bit relu_differs;
        bit accepted;
        bit ack_edge;
        bit finished;
        bit saw_stall;
        bit pix_xfer;

        // Reference model in window position then engine order
        n_pos        = t_count[t] - `KERNEL_TAPS + 1;
        relu_differs = 1'b0;
        for (int p = 0; p < n_pos; p++) begin
            for (int c = 0; c < `NUM_CE; c++) begin
                sum       = 0;
                sum_plain = 0;
                for (int k = 0; k < `KERNEL_TAPS; k++) begin
                    px = t_pixels[t][p + k];
                    sum_plain += t_kernel[t][c][k] * px;
                    if (t_relu[t] && px < 0) begin
                        px = 0;
                    end
                    sum += t_kernel[t][c][k] * px;
                end
                expected.push_back(sum);
                expected_plain.push_back(sum_plain);
            end
        end

        result_ready = 1'b1;
        load_weights(t);

        accept_cnt      = 0;
        complete_cycles = 0;
        pix_idx         = 0;
        res_idx         = 0;
        accepted        = 1'b0;
        ack_edge        = 1'b0;
        finished        = 1'b0;
        saw_stall       = 1'b0;
        job_num_pixels  = `COUNT_WIDTH'(t_count[t]);
        job_relu        = t_relu[t];
        job_start       = 1'b1;

        while (!finished) begin
            // Sample mid cycle and act after the edge
            @(negedge clk_core);
            pix_xfer = 1'b0;
            if (ack_edge) begin
                assert (!job_complete && weight_ready) else
                    protocol_error($sformatf("%s: quad not idle after job_complete_ack",
                                             t_name[t]));
                finished = 1'b1;
            end else begin
                if (job_accept) begin
                    accept_cnt++;
                    accepted = 1'b1;
                end
                if (accepted) begin
                    assert (!weight_ready) else
                        protocol_error($sformatf("%s: weight_ready high during the job",
                                                 t_name[t]));
                    if (!pixel_ready && pix_idx < t_count[t]) begin
                        saw_stall = 1'b1;
                    end
                end
                pix_xfer = pixel_valid && pixel_ready;
                if (job_complete) begin
                    if (complete_cycles == 0) begin
                        assert (res_idx == expected.size()) else
                            protocol_error($sformatf("%s: job_complete after %0d of %0d results",
                                                     t_name[t], res_idx, expected.size()));
                    end
                    complete_cycles++;
                    ack_edge = job_complete_ack;
                end else begin
                    assert (complete_cycles == 0) else begin
                        protocol_error($sformatf("%s: job_complete fell before job_complete_ack",
                                                 t_name[t]));
                        finished = 1'b1;
                    end
                end
                if (result_valid && result_ready) begin
                    assert (res_idx < expected.size()) else
                        protocol_error($sformatf("%s: result beyond the expected count",
                                                 t_name[t]));
                    if (res_idx < expected.size()) begin
                        check_value(t_name[t], $sformatf("result %0d", res_idx),
                                    expected[res_idx], int'(result_data));
                        if (int'(result_data) != expected_plain[res_idx]) begin
                            relu_differs = 1'b1;
                        end
                    end
                    res_idx++;
                end
            end

            @(posedge clk_core);
            #2;
            if (accepted) begin
                job_start = 1'b0;
            end
            if (pix_xfer) begin
                pix_idx++;
            end
            pixel_valid = accepted && (pix_idx < t_count[t]);
            if (pixel_valid) begin
                pixel_data = `PIXEL_WIDTH'(t_pixels[t][pix_idx]);
            end
            result_ready     = t_rand[t] ? ($random(seed) % 2 == 0) : 1'b1;
            // Hold off the ack a few cycles so the hold is visible
            job_complete_ack = (complete_cycles >= 3) && !ack_edge;
        end

        check_value(t_name[t], "job_accept pulses", 1, accept_cnt);
        check_value(t_name[t], "result count", expected.size(), res_idx);
        if (t_relu[t]) begin
            assert (relu_differs) else
                protocol_error($sformatf("%s: results under ReLU equal the plain convolution",
                                         t_name[t]));
        end
        if (t_rand[t]) begin
            assert (saw_stall) else
                protocol_error($sformatf("%s: pixel_ready never dropped under back-pressure",
                                         t_name[t]));
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rst              = 1'b1;
        job_start        = 1'b0;
        job_num_pixels   = '0;
        job_relu         = 1'b0;
        job_complete_ack = 1'b0;
        weight_valid     = 1'b0;
        weight_addr      = '0;
        weight_data      = '0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;
        result_ready     = 1'b1;

        fill_table();
        table_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_core);
        #2;
        rst = 1'b0;

        @(negedge clk_core);
        check_value("reset", "job_accept", 0, int'(job_accept));
        check_value("reset", "job_complete", 0, int'(job_complete));
        check_value("reset", "pixel_ready", 0, int'(pixel_ready));
        check_value("reset", "result_valid", 0, int'(result_valid));
        check_value("reset", "weight_ready", 1, int'(weight_ready));
        @(posedge clk_core);
        #2;

        for (int t = 0; t < N_TESTS; t++) begin
            run_row(t);
        end

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        wait (table_loaded);
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk_core);
        $display("Timeout: the run did not end within %0d clock cycles", limit);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/quad_pkg.sv
design/job_ctrl.sv
design/prefetch_buffer.sv
design/pixel_window.sv
design/weight_table.sv
design/conv_engine.sv
design/result_serializer.sv
design/quad_top.sv
tests/quad_asserts.sv
tests/quad_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the quad testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module quad_tb -f filelist.f -o quad_sim

# The log decides the result, so a stopped simulation must not end the script here
./obj_dir/quad_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
